/* cache_system.f */
common/axil_pkg.sv
common/cache_pkg.sv
common/axil_if.sv
cache/cache_store.sv
cache/cache_ctrl.sv
logic/axil_memory.sv
logic/cache_system.sv
test/cache_system_asserts.sv
test/cache_system_tb.sv

/* test/cache_system_tb.sv */
module cache_system_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import axil_pkg::*;

  localparam int TIMEOUT = 100;

  typedef struct {
    logic  is_write;
    addr_t addr;
    data_t data;
    strb_t strb;
    logic  exp_hit;
    int    hold;
  } entry_t;

  logic  ACLK;
  logic  ARESETn;
  logic  arvalid;
  logic  arready;
  addr_t araddr;
  logic  rvalid;
  logic  rready;
  data_t rdata;
  resp_t rresp;
  logic  awvalid;
  logic  awready;
  addr_t awaddr;
  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;
  logic  bvalid;
  logic  bready;
  resp_t bresp;

  entry_t entries[$];
  data_t  model[addr_t];
  int     seed = 97;

  cache_system u_cache_system (.*);

  always #10 ACLK = ~ACLK;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Stopped at first error");
    end
  endtask

  // Expected memory word after a strobed write
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return result;
  endfunction

  function automatic logic flag_high(input int sel);
    case (sel)
      0:       return arready;
      1:       return awready && wready;
      2:       return rvalid;
      default: return bvalid;
    endcase
  endfunction

  // Poll at the falling edge where DUT outputs are settled
  task automatic wait_flag(input int sel, input string name);
    int waited;
    waited = 0;
    @(negedge ACLK);
    while (!flag_high(sel)) begin
      if (waited >= TIMEOUT) begin
        $display("ERROR: timed out at %0t ns waiting for %s", $time, name);
        $display("Simulation failed");
        $fatal(1, "Wait limit reached");
      end else begin
        waited++;
        @(negedge ACLK);
      end
    end
  endtask

  task automatic add_entry(input logic wr, input addr_t addr, input data_t data,
                           input strb_t strb, input logic exp_hit, input int hold);
    entry_t e;
    e = '{wr, addr, data, strb, exp_hit, hold};
    entries.push_back(e);
  endtask

  task automatic apply_entry(input entry_t e);
    int    hold;
    data_t expected;
    // Negative hold means a random ready delay
    hold = (e.hold < 0) ? ($unsigned($random(seed)) % 6) : e.hold;
    @(posedge ACLK);
    if (e.is_write) begin
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      awaddr  <= e.addr;
      wdata   <= e.data;
      wstrb   <= e.strb;
      wait_flag(1, "awready and wready");
      @(posedge ACLK);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      model[e.addr] = merge_bytes(model.exists(e.addr) ? model[e.addr] : '0, e.data, e.strb);
      wait_flag(3, "bvalid");
      check_value("bresp", bresp, RESP_OKAY);
      repeat (hold) begin
        @(negedge ACLK);
        check_value("bvalid", bvalid, 1'b1);
        check_value("arready", arready, 1'b0);
        check_value("awready", awready, 1'b0);
      end
      @(posedge ACLK);
      bready <= 1'b1;
      @(negedge ACLK);
      check_value("bvalid", bvalid, 1'b1);
      @(posedge ACLK);
      bready <= 1'b0;
    end else begin
      expected = model[e.addr];
      arvalid <= 1'b1;
      araddr  <= e.addr;
      wait_flag(0, "arready");
      @(posedge ACLK);
      arvalid <= 1'b0;
      // By now a hit already has rvalid up and a miss is still filling
      repeat (2) @(negedge ACLK);
      check_value("rvalid", rvalid, e.exp_hit);
      if (!e.exp_hit) begin
        wait_flag(2, "rvalid");
      end
      check_value("rdata", rdata, expected);
      check_value("rresp", rresp, RESP_OKAY);
      repeat (hold) begin
        @(negedge ACLK);
        check_value("rvalid", rvalid, 1'b1);
        check_value("rdata", rdata, expected);
        check_value("arready", arready, 1'b0);
      end
      @(posedge ACLK);
      rready <= 1'b1;
      @(negedge ACLK);
      check_value("rvalid", rvalid, 1'b1);
      check_value("rdata", rdata, expected);
      @(posedge ACLK);
      rready <= 1'b0;
    end
  endtask

  initial begin
    ACLK    = 1'b0;
    ARESETn = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;

    // Fill then hit, partial write hit, same-index conflict
    add_entry(1'b1, 32'h0000_0010, 32'hDEAD_BEEF, 4'b1111, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0010, '0, '0, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0010, '0, '0, 1'b1, 1);
    add_entry(1'b1, 32'h0000_0010, 32'h00A5_00C3, 4'b0101, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0010, '0, '0, 1'b1, 0);
    add_entry(1'b1, 32'h0000_0014, 32'h1111_2222, 4'b1111, 1'b0, 0);
    add_entry(1'b1, 32'h0000_0114, 32'h3333_4444, 4'b1111, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0014, '0, '0, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0114, '0, '0, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0014, '0, '0, 1'b0, 2);
    add_entry(1'b0, 32'h0000_0114, '0, '0, 1'b0, 0);
    // Writes to uncached targets do not allocate
    add_entry(1'b1, 32'h0000_0040, 32'h5566_7788, 4'b1111, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0040, '0, '0, 1'b0, 0);
    add_entry(1'b0, 32'h0000_0014, '0, '0, 1'b0, 0);
    add_entry(1'b1, 32'h0000_0114, 32'h9ABC_DEF0, 4'b0011, 1'b0, 1);
    add_entry(1'b0, 32'h0000_0114, '0, '0, 1'b0, 0);
    // Random back-pressure on R and B
    add_entry(1'b1, 32'h0000_0080, 32'hCAFE_F00D, 4'b1111, 1'b0, -1);
    add_entry(1'b0, 32'h0000_0080, '0, '0, 1'b0, -1);
    add_entry(1'b0, 32'h0000_0080, '0, '0, 1'b1, -1);
    add_entry(1'b1, 32'h0000_0084, 32'h0BAD_C0DE, 4'b1111, 1'b0, -1);
    add_entry(1'b1, 32'h0000_0084, 32'h7700_0000, 4'b1100, 1'b0, -1);
    add_entry(1'b0, 32'h0000_0084, '0, '0, 1'b0, -1);
    add_entry(1'b0, 32'h0000_0080, '0, '0, 1'b1, -1);

    repeat (2) @(posedge ACLK);
    ARESETn <= 1'b1;
    @(negedge ACLK);
    check_value("rvalid", rvalid, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    check_value("arready", arready, 1'b1);
    check_value("awready", awready, 1'b1);
    check_value("wready", wready, 1'b1);

    foreach (entries[i]) begin
      apply_entry(entries[i]);
    end
    repeat (2) @(posedge ACLK);

    if (u_cache_system.u_asserts.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* test/cache_system_asserts.sv */
module cache_system_asserts (
  input logic            ACLK,
  input logic            ARESETn,
  input logic            arready,
  input logic            rvalid,
  input logic            rready,
  input axil_pkg::data_t rdata,
  input logic            bvalid,
  input logic            bready
);
  timeunit 1ns;
  timeprecision 1ns;

  int fail_count = 0;

  // Read response held under back-pressure
  r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      $error("rvalid or rdata changed while rready was low");
      fail_count++;
    end

  b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped while bready was low");
      fail_count++;
    end

  // Responses idle once reset has been seen
  reset_idle: assert property (@(posedge ACLK) !ARESETn |=> !rvalid && !bvalid)
    else begin
      $error("rvalid or bvalid high after reset");
      fail_count++;
    end

  one_in_flight: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rvalid |-> !arready)
    else begin
      $error("arready high while a read response is pending");
      fail_count++;
    end

endmodule

bind cache_system cache_system_asserts u_asserts (
  .ACLK    (ACLK),
  .ARESETn (ARESETn),
  .arready (arready),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata),
  .bvalid  (bvalid),
  .bready  (bready)
);

/* logic/cache_system.sv */
module cache_system (
  input  logic            ACLK,
  input  logic            ARESETn,
  input  logic            arvalid,
  output logic            arready,
  input  axil_pkg::addr_t araddr,
  output logic            rvalid,
  input  logic            rready,
  output axil_pkg::data_t rdata,
  output axil_pkg::resp_t rresp,
  input  logic            awvalid,
  output logic            awready,
  input  axil_pkg::addr_t awaddr,
  input  logic            wvalid,
  output logic            wready,
  input  axil_pkg::data_t wdata,
  input  axil_pkg::strb_t wstrb,
  output logic            bvalid,
  input  logic            bready,
  output axil_pkg::resp_t bresp
);
  import axil_pkg::*;

  logic  hit;
  data_t line_data;
  addr_t req_addr;
  logic  line_we;
  strb_t line_strb;
  data_t line_wdata;

  // The cache never reports an error
  assign rresp = RESP_OKAY;
  assign bresp = RESP_OKAY;

  axil_if mem_bus ();

  cache_ctrl u_cache_ctrl (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .hit        (hit),
    .line_data  (line_data),
    .req_addr   (req_addr),
    .line_we    (line_we),
    .line_strb  (line_strb),
    .line_wdata (line_wdata),
    .mem        (mem_bus.manager)
  );

  cache_store u_cache_store (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .req_addr   (req_addr),
    .line_we    (line_we),
    .line_strb  (line_strb),
    .line_wdata (line_wdata),
    .hit        (hit),
    .line_data  (line_data)
  );

  axil_memory u_axil_memory (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .bus     (mem_bus.subord)
  );

endmodule

/* logic/axil_memory.sv */
module axil_memory (
  input logic    ACLK,
  input logic    ARESETn,
  axil_if.subord bus
);
  import axil_pkg::*;
  import cache_pkg::*;

  data_t mem_q [MEM_WORDS];

  logic [MEM_INDEX_BITS-1:0] rd_index;
  logic [MEM_INDEX_BITS-1:0] wr_index;
  logic                      ar_hs;
  logic                      wr_hs;

  assign rd_index = bus.araddr[OFFSET_BITS +: MEM_INDEX_BITS];
  assign wr_index = bus.awaddr[OFFSET_BITS +: MEM_INDEX_BITS];

  // No new request on a channel while its response is still pending
  assign bus.arready = !bus.rvalid;
  assign bus.awready = !bus.bvalid;
  assign bus.wready  = !bus.bvalid;

  assign ar_hs = bus.arvalid && bus.arready;
  assign wr_hs = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      bus.rvalid <= 1'b0;
      bus.bvalid <= 1'b0;
    end else begin
      if (ar_hs) begin
        bus.rvalid <= 1'b1;
      end else if (bus.rvalid && bus.rready) begin
        bus.rvalid <= 1'b0;
      end
      if (wr_hs) begin
        bus.bvalid <= 1'b1;
      end else if (bus.bvalid && bus.bready) begin
        bus.bvalid <= 1'b0;
      end
    end
  end

  // Read data is registered and held with rvalid
  always_ff @(posedge ACLK) begin
    if (ar_hs) begin
      bus.rdata <= mem_q[rd_index];
    end
    if (wr_hs) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (bus.wstrb[i]) begin
          mem_q[wr_index][i*8 +: 8] <= bus.wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

/* cache/cache_ctrl.sv */
module cache_ctrl (
  input  logic            ACLK,
  input  logic            ARESETn,
  input  logic            arvalid,
  output logic            arready,
  input  axil_pkg::addr_t araddr,
  output logic            rvalid,
  input  logic            rready,
  output axil_pkg::data_t rdata,
  input  logic            awvalid,
  output logic            awready,
  input  axil_pkg::addr_t awaddr,
  input  logic            wvalid,
  output logic            wready,
  input  axil_pkg::data_t wdata,
  input  axil_pkg::strb_t wstrb,
  output logic            bvalid,
  input  logic            bready,
  input  logic            hit,
  input  axil_pkg::data_t line_data,
  output axil_pkg::addr_t req_addr,
  output logic            line_we,
  output axil_pkg::strb_t line_strb,
  output axil_pkg::data_t line_wdata,
  axil_if.manager         mem
);
  import axil_pkg::*;
  import cache_pkg::*;

  cache_state_t state;
  data_t        req_data;
  strb_t        req_strb;
  logic         req_write;
  logic         ar_accept;
  logic         wr_accept;
  logic         fill_beat;
  logic         b_beat;

  // Reads win over writes when both arrive in the same idle cycle
  assign arready = (state == CACHE_IDLE);
  assign awready = (state == CACHE_IDLE) && !arvalid;
  assign wready  = (state == CACHE_IDLE) && !arvalid;

  assign ar_accept = arvalid && arready;
  assign wr_accept = awvalid && wvalid && awready && wready;

  // Memory requests always use the latched request
  assign mem.araddr = req_addr;
  assign mem.awaddr = req_addr;
  assign mem.wdata  = req_data;
  assign mem.wstrb  = req_strb;
  assign mem.rready = (state == CACHE_FILL);
  assign mem.bready = (state == CACHE_WRITE_MEM);

  assign fill_beat = (state == CACHE_FILL) && mem.rvalid;
  assign b_beat    = (state == CACHE_WRITE_MEM) && mem.bvalid;

  // Fill writes the whole word, a write hit merges under the request strobes
  assign line_we    = fill_beat || (b_beat && hit);
  assign line_strb  = fill_beat ? '1 : req_strb;
  assign line_wdata = fill_beat ? mem.rdata : req_data;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state       <= CACHE_IDLE;
      rvalid      <= 1'b0;
      bvalid      <= 1'b0;
      mem.arvalid <= 1'b0;
      mem.awvalid <= 1'b0;
      mem.wvalid  <= 1'b0;
    end else begin
      case (state)
        CACHE_IDLE: begin
          if (ar_accept) begin
            state <= CACHE_LOOKUP;
          end else if (wr_accept) begin
            state       <= CACHE_WRITE_MEM;
            mem.awvalid <= 1'b1;
            mem.wvalid  <= 1'b1;
          end
        end
        CACHE_LOOKUP: begin
          if (hit) begin
            rvalid <= 1'b1;
            state  <= CACHE_RESPOND;
          end else begin
            mem.arvalid <= 1'b1;
            state       <= CACHE_FILL;
          end
        end
        CACHE_FILL: begin
          if (mem.arvalid && mem.arready) begin
            mem.arvalid <= 1'b0;
          end
          if (fill_beat) begin
            rvalid <= 1'b1;
            state  <= CACHE_RESPOND;
          end
        end
        CACHE_WRITE_MEM: begin
          // AW and W go out together and are accepted together
          if (mem.awvalid && mem.awready && mem.wvalid && mem.wready) begin
            mem.awvalid <= 1'b0;
            mem.wvalid  <= 1'b0;
          end
          if (b_beat) begin
            bvalid <= 1'b1;
            state  <= CACHE_RESPOND;
          end
        end
        CACHE_RESPOND: begin
          if (req_write && bready) begin
            bvalid <= 1'b0;
            state  <= CACHE_IDLE;
          end else if (!req_write && rready) begin
            rvalid <= 1'b0;
            state  <= CACHE_IDLE;
          end
        end
        default: state <= CACHE_IDLE;
      endcase
    end
  end

  // Request payload and read data
  always_ff @(posedge ACLK) begin
    if (ar_accept) begin
      req_addr  <= araddr;
      req_write <= 1'b0;
    end else if (wr_accept) begin
      req_addr  <= awaddr;
      req_data  <= wdata;
      req_strb  <= wstrb;
      req_write <= 1'b1;
    end
    if ((state == CACHE_LOOKUP) && hit) begin
      rdata <= line_data;
    end else if (fill_beat) begin
      rdata <= mem.rdata;
    end
  end

endmodule

/* cache/cache_store.sv */
module cache_store (
  input  logic            ACLK,
  input  logic            ARESETn,
  input  axil_pkg::addr_t req_addr,
  input  logic            line_we,
  input  axil_pkg::strb_t line_strb,
  input  axil_pkg::data_t line_wdata,
  output logic            hit,
  output axil_pkg::data_t line_data
);
  import axil_pkg::*;
  import cache_pkg::*;

  logic [NUM_SETS-1:0] valid_q;
  tag_t                tag_q  [NUM_SETS];
  data_t               data_q [NUM_SETS];

  index_t req_index;
  tag_t   req_tag;

  // Address splits into tag, index and byte offset
  assign req_index = req_addr[OFFSET_BITS +: INDEX_BITS];
  assign req_tag   = req_addr[ADDR_WIDTH-1 -: TAG_BITS];

  assign hit       = valid_q[req_index] && (tag_q[req_index] == req_tag);
  assign line_data = data_q[req_index];

  // All lines start invalid
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
    end else if (line_we) begin
      valid_q[req_index] <= 1'b1;
    end
  end

  always_ff @(posedge ACLK) begin
    if (line_we) begin
      tag_q[req_index] <= req_tag;
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (line_strb[i]) begin
          data_q[req_index][i*8 +: 8] <= line_wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

/* common/axil_if.sv */
interface axil_if;
  import axil_pkg::*;

  logic  arvalid;
  logic  arready;
  addr_t araddr;

  logic  rvalid;
  logic  rready;
  data_t rdata;

  logic  awvalid;
  logic  awready;
  addr_t awaddr;

  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;

  logic  bvalid;
  logic  bready;

  // Cache side issues requests
  modport manager(
    output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  arready, rvalid, rdata, awready, wready, bvalid
  );

  // Memory side answers them
  modport subord(
    input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arready, rvalid, rdata, awready, wready, bvalid
  );
endinterface

/* common/cache_pkg.sv */
package cache_pkg;

  // Direct-mapped geometry with one word per line
  localparam int NUM_SETS    = 4;
  localparam int OFFSET_BITS = 2;
  localparam int INDEX_BITS  = $clog2(NUM_SETS);
  localparam int TAG_BITS    = axil_pkg::ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  // Backing memory depth in words
  localparam int MEM_WORDS      = 256;
  localparam int MEM_INDEX_BITS = $clog2(MEM_WORDS);

  // Controller FSM with one request in flight
  typedef enum logic [2:0] {
    CACHE_IDLE,
    CACHE_LOOKUP,
    CACHE_FILL,
    CACHE_WRITE_MEM,
    CACHE_RESPOND
  } cache_state_t;

endpackage

/* common/axil_pkg.sv */
package axil_pkg;

  // AXI-Lite bus geometry
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  // Response codes as carried on RRESP and BRESP
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

endpackage
